/* include/wr_router_cfg.svh */
// Width, depth and credit macros for the RDMA write-data router
`ifndef WR_ROUTER_CFG_SVH
`define WR_ROUTER_CFG_SVH

// --------------------------------------------------------------------------
// Payload stream
// --------------------------------------------------------------------------
// Data bus width in bits
`define WR_DATA_BITS 64
// One keep bit per data byte
`define WR_KEEP_BITS (`WR_DATA_BITS / 8)
// Stream id carried with each beat
`define WR_TID_BITS 6

// --------------------------------------------------------------------------
// Request fields
// --------------------------------------------------------------------------
// Beat count minus one
`define WR_LEN_BITS 8
`define WR_VADDR_BITS 48
// Same width as the stream id
`define WR_REQ_ID_BITS 6

// Buffer depths and credits per destination sink
`define WR_BEAT_FIFO_DEPTH 16
`define WR_SQ_DEPTH 4
`define WR_DEST_CREDITS 4

`endif

/* verilog/rdma_req_pkg.sv */
// Request struct, destination enum and route state enum for the write router
`include "wr_router_cfg.svh"

package rdma_req_pkg;

  // --------------------------------------------------------------------------
  // Destination select
  // --------------------------------------------------------------------------
  // Single bit from the request with card as the zero encoding
  typedef enum logic {
    DEST_CARD = 1'b0,
    DEST_HOST = 1'b1
  } dest_e;

  // Write request as it arrives and as it leaves on the send queue
  // 48 + 8 + 1 + 6 = 63 bits
  typedef struct packed {
    logic [`WR_VADDR_BITS-1:0]  vaddr;
    logic [`WR_LEN_BITS-1:0]    len;
    dest_e                      dest;
    logic [`WR_REQ_ID_BITS-1:0] req_id;
  } req_t;

  // Controller states
  typedef enum logic {
    ST_IDLE  = 1'b0,
    ST_ROUTE = 1'b1
  } route_state_e;

endpackage

/* verilog/axis_beat_pkg.sv */
// Stream beat struct shared by the payload input and both destination ports
`include "wr_router_cfg.svh"

package axis_beat_pkg;

  // --------------------------------------------------------------------------
  // Payload beat
  // --------------------------------------------------------------------------
  // 64 + 8 + 1 + 6 = 79 bits
  typedef struct packed {
    // Payload bytes
    logic [`WR_DATA_BITS-1:0] data;
    // Byte enables
    logic [`WR_KEEP_BITS-1:0] keep;
    // Final beat of a transfer
    logic                     last;
    // Stream id
    logic [`WR_TID_BITS-1:0]  tid;
  } beat_t;

endpackage

/* verilog/sync_fifo.sv */
// Synchronous FIFO with a type parameter, circular buffer and fill count
`timescale 1ns/10ps

module sync_fifo #(
  parameter type item_t = logic [7:0],
  parameter int  DEPTH  = 4
) (
  input  logic  aclk,
  input  logic  aresetn,
  // Write side
  input  logic  in_valid,
  output logic  in_ready,
  input  item_t in_item,
  // Read side
  output logic  out_valid,
  input  logic  out_ready,
  output item_t out_item
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Entry storage
  item_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_en;
  logic             rd_en;

  // --------------------------------------------------------------------------
  // Handshakes
  // --------------------------------------------------------------------------
  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  // Head entry comes straight from the array registers
  assign out_item  = mem[rd_ptr];

  assign wr_en = in_valid && in_ready;
  assign rd_en = out_valid && out_ready;

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_item;
    end
  end

  // Pointers wrap at DEPTH so non power of two depths work too
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  // Full buffer must not take another entry
  a_no_write_full: assert property (@(posedge aclk) disable iff (!aresetn)
    (count == CNT_W'(DEPTH)) |=> (wr_ptr == $past(wr_ptr)));

  // Empty buffer must not advance the head
  a_no_read_empty: assert property (@(posedge aclk) disable iff (!aresetn)
    (count == '0) |=> (rd_ptr == $past(rd_ptr)));

endmodule

/* verilog/dest_credit_port.sv */
// Credit counter and registered beat output for one destination stream
`timescale 1ns/10ps
`include "wr_router_cfg.svh"

module dest_credit_port
  import axis_beat_pkg::*;
#(
  parameter int CREDITS = `WR_DEST_CREDITS
) (
  input  logic  aclk,
  input  logic  aresetn,
  // From the controller and the beat buffer
  input  logic  push,
  input  beat_t beat,
  output logic  has_credit,
  // Slot returned by the sink
  input  logic  credit,
  // Toward the sink
  output logic  out_valid,
  output beat_t out_beat
);

  localparam int CNT_W = $clog2(CREDITS + 1);

  logic [CNT_W-1:0] credit_cnt;

  // Pop is allowed only with a free slot at the sink
  assign has_credit = (credit_cnt != '0);

  // --------------------------------------------------------------------------
  // Credit counter
  // --------------------------------------------------------------------------
  // Spend and return may land in the same cycle and cancel
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      credit_cnt <= CNT_W'(CREDITS);
    end else begin
      case ({push, credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // Output stage one cycle after the pop
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= push;
    end
  end

  always_ff @(posedge aclk) begin
    if (push) begin
      out_beat <= beat;
    end
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  // Controller only pushes while this port holds a credit
  a_push_with_credit: assert property (@(posedge aclk) disable iff (!aresetn)
    push |-> has_credit);

  // Sink never returns more slots than it has
  a_credit_bound: assert property (@(posedge aclk) disable iff (!aresetn)
    credit_cnt <= CNT_W'(CREDITS));

endmodule

/* verilog/wr_route_ctrl.sv */
// Routing FSM that accepts requests, counts beats and steers pops to a port
`timescale 1ns/10ps
`include "wr_router_cfg.svh"

module wr_route_ctrl
  import rdma_req_pkg::*;
(
  input  logic aclk,
  input  logic aresetn,
  // Request port
  input  logic rq_valid,
  output logic rq_ready,
  input  req_t rq,
  // Send queue write side
  output logic sq_push,
  input  logic sq_full,
  // Beat buffer head
  input  logic beat_avail,
  output logic beat_pop,
  // Destination ports
  input  logic host_credit_ok,
  input  logic card_credit_ok,
  output logic host_push,
  output logic card_push
);

  route_state_e state;

  // Beats left minus one, and the latched target
  logic [`WR_LEN_BITS-1:0] beat_cnt;
  dest_e                   dest;

  logic sel_credit;
  logic last_pop;
  logic take_rq;

  // --------------------------------------------------------------------------
  // Steering
  // --------------------------------------------------------------------------
  assign sel_credit = (dest == DEST_HOST) ? host_credit_ok : card_credit_ok;

  // One pop per cycle while routing and the target has credit
  assign beat_pop  = (state == ST_ROUTE) && beat_avail && sel_credit;
  assign host_push = beat_pop && (dest == DEST_HOST);
  assign card_push = beat_pop && (dest == DEST_CARD);

  // Final beat of the current request leaves this cycle
  assign last_pop = beat_pop && (beat_cnt == '0);

  // Ready answers a valid request when idle or on the last pop
  // Requests chain with no gap
  assign rq_ready = rq_valid && ((state == ST_IDLE) || last_pop) && !sq_full;
  assign take_rq  = rq_valid && rq_ready;
  // Request goes to the send queue in the cycle it is taken
  assign sq_push  = take_rq;

  // --------------------------------------------------------------------------
  // State and counter
  // --------------------------------------------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state    <= ST_IDLE;
      beat_cnt <= '0;
      dest     <= DEST_CARD;
    end else begin
      if (take_rq) begin
        state    <= ST_ROUTE;
        beat_cnt <= rq.len;
        dest     <= rq.dest;
      end else if (last_pop) begin
        // No follow-up request ready
        state <= ST_IDLE;
      end else if (beat_pop) begin
        beat_cnt <= beat_cnt - 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  // A beat goes to exactly one destination
  a_one_push: assert property (@(posedge aclk) disable iff (!aresetn)
    !(host_push && card_push));

endmodule

/* verilog/wr_data_router_top.sv */
// Top of the write-data router with beat buffer, send queue, FSM and ports
`timescale 1ns/10ps
`include "wr_router_cfg.svh"

module wr_data_router_top
  import rdma_req_pkg::*, axis_beat_pkg::*;
(
  input  logic  aclk,
  input  logic  aresetn,
  // Incoming write requests
  input  logic  s_rq_valid,
  output logic  s_rq_ready,
  input  req_t  s_rq,
  // Incoming payload
  input  logic  s_axis_valid,
  output logic  s_axis_ready,
  input  beat_t s_axis,
  // Forwarded requests
  output logic  m_sq_valid,
  input  logic  m_sq_ready,
  output req_t  m_sq,
  // Credit based host destination
  output logic  m_host_valid,
  output beat_t m_host,
  input  logic  host_credit,
  // Credit based card destination
  output logic  m_card_valid,
  output beat_t m_card,
  input  logic  card_credit
);

  beat_t beat_q;
  logic  beat_avail;
  logic  beat_pop;
  logic  sq_push;
  logic  sq_ready;
  logic  sq_full;
  logic  host_push;
  logic  card_push;
  logic  host_credit_ok;
  logic  card_credit_ok;

  assign sq_full = !sq_ready;

  // --------------------------------------------------------------------------
  // Buffers
  // --------------------------------------------------------------------------
  // Payload may lead its request and waits here
  sync_fifo #(.item_t(beat_t), .DEPTH(`WR_BEAT_FIFO_DEPTH)) beat_fifo (
    .aclk(aclk), .aresetn(aresetn),
    .in_valid(s_axis_valid), .in_ready(s_axis_ready), .in_item(s_axis),
    .out_valid(beat_avail), .out_ready(beat_pop), .out_item(beat_q)
  );

  // Requests pass through unchanged
  sync_fifo #(.item_t(req_t), .DEPTH(`WR_SQ_DEPTH)) sq_fifo (
    .aclk(aclk), .aresetn(aresetn),
    .in_valid(sq_push), .in_ready(sq_ready), .in_item(s_rq),
    .out_valid(m_sq_valid), .out_ready(m_sq_ready), .out_item(m_sq)
  );

  wr_route_ctrl route_ctrl (
    .aclk(aclk), .aresetn(aresetn),
    .rq_valid(s_rq_valid), .rq_ready(s_rq_ready), .rq(s_rq),
    .sq_push(sq_push), .sq_full(sq_full),
    .beat_avail(beat_avail), .beat_pop(beat_pop),
    .host_credit_ok(host_credit_ok), .card_credit_ok(card_credit_ok),
    .host_push(host_push), .card_push(card_push)
  );

  // --------------------------------------------------------------------------
  // Destination ports
  // --------------------------------------------------------------------------
  // Head beat fans out to both and only one gets the push strobe
  dest_credit_port #(.CREDITS(`WR_DEST_CREDITS)) host_port (
    .aclk(aclk), .aresetn(aresetn),
    .push(host_push), .beat(beat_q), .has_credit(host_credit_ok),
    .credit(host_credit), .out_valid(m_host_valid), .out_beat(m_host)
  );

  dest_credit_port #(.CREDITS(`WR_DEST_CREDITS)) card_port (
    .aclk(aclk), .aresetn(aresetn),
    .push(card_push), .beat(beat_q), .has_credit(card_credit_ok),
    .credit(card_credit), .out_valid(m_card_valid), .out_beat(m_card)
  );

endmodule

/* testbench/tb_wr_data_router.sv */
// Testbench with clock, reset, stimulus, credit sinks, reference model and compare tasks
`timescale 1ns/10ps
`include "wr_router_cfg.svh"

module tb_wr_data_router
  import rdma_req_pkg::*, axis_beat_pkg::*;
();

  localparam int SEED        = 32'h3a9b;
  localparam int NUM_REQ     = 40;
  localparam int NUM_B2B     = 12;
  localparam int WAIT_LIMIT  = 1000;
  localparam int DRAIN_LIMIT = 20000;
  localparam int STALL_AFTER = 12;

  typedef req_t  req_list_t[$];
  typedef beat_t beat_list_t[$];

  // DUT inputs start at a known value
  logic       aclk         = 1'b0;
  logic       aresetn      = 1'b0;
  logic       s_rq_valid   = 1'b0;
  req_t       s_rq         = '0;
  logic       s_axis_valid = 1'b0;
  beat_t      s_axis       = '0;
  logic       m_sq_ready   = 1'b0;
  // Index 1 is host and 0 is card as in the dest encoding
  logic [1:0] credit_out   = 2'b00;

  logic  s_rq_ready;
  logic  s_axis_ready;
  logic  m_sq_valid;
  req_t  m_sq;
  logic  m_host_valid;
  beat_t m_host;
  logic  m_card_valid;
  beat_t m_card;
  logic [1:0] sink_valid;

  // Separate seeds per process
  integer seed      = SEED;
  integer rq_seed   = SEED ^ 32'h0011;
  integer ax_seed   = SEED ^ 32'h0022;
  integer sq_seed   = SEED ^ 32'h0033;
  integer sink_seed = SEED ^ 32'h0044;

  req_list_t  req_list;
  beat_list_t beat_list;
  req_list_t  sq_exp;
  beat_list_t host_exp;
  beat_list_t card_exp;
  int         used [2];
  int         host_seen      = 0;
  logic       host_hold      = 1'b0;
  logic       axis_drop_seen = 1'b0;

  always #5 aclk = ~aclk;

  assign sink_valid = {m_host_valid, m_card_valid};

  wr_data_router_top dut (
    .aclk(aclk), .aresetn(aresetn),
    .s_rq_valid(s_rq_valid), .s_rq_ready(s_rq_ready), .s_rq(s_rq),
    .s_axis_valid(s_axis_valid), .s_axis_ready(s_axis_ready), .s_axis(s_axis),
    .m_sq_valid(m_sq_valid), .m_sq_ready(m_sq_ready), .m_sq(m_sq),
    .m_host_valid(m_host_valid), .m_host(m_host), .host_credit(credit_out[1]),
    .m_card_valid(m_card_valid), .m_card(m_card), .card_credit(credit_out[0])
  );

  // --------------------------------------------------------------------------
  // Reporting and compare tasks
  // --------------------------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
      abort_run("Flag differs from the expected value");
    end
  endtask

  task automatic check_req(input string name, input req_t exp, input req_t act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
      abort_run("Request differs from the reference model");
    end
  endtask

  task automatic check_beat(input string name, input beat_t exp, input beat_t act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
      abort_run("Beat differs from the reference model");
    end
  endtask

  // --------------------------------------------------------------------------
  // Stimulus and reference model
  // --------------------------------------------------------------------------
  // Random requests first, then a tail of one-beat requests with alternating dest
  task automatic build_stimulus();
    req_t  r;
    beat_t b;
    int    i;
    int    n;
    for (i = 0; i < NUM_REQ + NUM_B2B; i++) begin
      r.vaddr  = {16'($random(seed)), 32'($random(seed))};
      r.req_id = 6'(i);
      if (i < NUM_REQ) begin
        r.len  = 8'({$random(seed)} % 8);
        r.dest = ($random(seed) & 1) ? DEST_HOST : DEST_CARD;
      end else begin
        r.len  = '0;
        r.dest = (i % 2 == 1) ? DEST_HOST : DEST_CARD;
      end
      req_list.push_back(r);
      for (n = 0; n <= int'(r.len); n++) begin
        b.data = {$random(seed), $random(seed)};
        b.keep = 8'($random(seed));
        b.last = (n == int'(r.len));
        b.tid  = r.req_id;
        beat_list.push_back(b);
      end
    end
  endtask

  // Beats are consumed in order, len+1 per request, to the request's dest
  function automatic void expect_route(input req_list_t rqs, input beat_list_t bts,
                                       output beat_list_t host_q, output beat_list_t card_q);
    int idx;
    int n;
    idx    = 0;
    host_q = {};
    card_q = {};
    foreach (rqs[i]) begin
      for (n = 0; n <= int'(rqs[i].len); n++) begin
        if (rqs[i].dest == DEST_HOST) begin
          host_q.push_back(bts[idx]);
        end else begin
          card_q.push_back(bts[idx]);
        end
        idx++;
      end
    end
  endfunction

  task automatic drive_requests();
    int i;
    int gap;
    int wait_cnt;
    for (i = 0; i < req_list.size(); i++) begin
      s_rq_valid <= 1'b1;
      s_rq       <= req_list[i];
      wait_cnt = 0;
      do begin
        @(posedge aclk);
        wait_cnt++;
        if (wait_cnt > WAIT_LIMIT) begin
          abort_run("Timed out waiting for the request port to accept a request");
        end
      end while (!s_rq_ready);
      // Tail requests chain with no gap
      gap = (i < NUM_REQ) ? {$random(rq_seed)} % 4 : 0;
      if (gap > 0) begin
        s_rq_valid <= 1'b0;
        repeat (gap) @(posedge aclk);
      end
    end
    s_rq_valid <= 1'b0;
  endtask

  task automatic drive_beats();
    int i;
    int wait_cnt;
    for (i = 0; i < beat_list.size(); i++) begin
      s_axis_valid <= 1'b1;
      s_axis       <= beat_list[i];
      wait_cnt = 0;
      do begin
        @(posedge aclk);
        wait_cnt++;
        if (wait_cnt > WAIT_LIMIT) begin
          abort_run("Timed out waiting for the payload input to accept a beat");
        end
      end while (!s_axis_ready);
      if ({$random(ax_seed)} % 4 == 0) begin
        s_axis_valid <= 1'b0;
        @(posedge aclk);
      end
    end
    s_axis_valid <= 1'b0;
  endtask

  // Host sink keeps its credits for 200 cycles once some host traffic has passed
  task automatic stall_host();
    int wait_cnt;
    wait_cnt = 0;
    while (host_seen < STALL_AFTER) begin
      @(posedge aclk);
      wait_cnt++;
      if (wait_cnt > DRAIN_LIMIT) begin
        abort_run("Timed out waiting for host beats before the stall phase");
      end
    end
    host_hold <= 1'b1;
    repeat (200) @(posedge aclk);
    host_hold <= 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Sinks and output compare
  // --------------------------------------------------------------------------
  always @(posedge aclk) begin
    m_sq_ready <= ({$random(sq_seed)} % 4) != 0;
  end

  // Each sink frees one slot at a random time and counts its own occupancy
  always @(posedge aclk) begin : credit_sinks
    int used_n;
    int p;
    if (!aresetn) begin
      credit_out <= 2'b00;
      used[0] = 0;
      used[1] = 0;
    end else begin
      for (p = 0; p < 2; p++) begin
        used_n = used[p] + (sink_valid[p] ? 1 : 0);
        if (used_n > `WR_DEST_CREDITS) begin
          abort_run("A sink received more beats than it has buffer slots");
        end
        if (used_n > 0 && !(p == 1 && host_hold) && ({$random(sink_seed)} % 3 == 0)) begin
          credit_out[p] <= 1'b1;
          used_n = used_n - 1;
        end else begin
          credit_out[p] <= 1'b0;
        end
        used[p] = used_n;
      end
    end
  end

  always @(posedge aclk) begin : compare_outputs
    if (aresetn) begin
      if (m_sq_valid && m_sq_ready) begin
        if (sq_exp.size() == 0) begin
          abort_run("A request left on m_sq when none was expected");
        end else begin
          check_req("m_sq", sq_exp.pop_front(), m_sq);
        end
      end
      if (m_host_valid) begin
        if (host_exp.size() == 0) begin
          abort_run("A beat appeared on m_host when none was expected");
        end else begin
          check_beat("m_host", host_exp.pop_front(), m_host);
        end
        host_seen <= host_seen + 1;
      end
      if (m_card_valid) begin
        if (card_exp.size() == 0) begin
          abort_run("A beat appeared on m_card when none was expected");
        end else begin
          check_beat("m_card", card_exp.pop_front(), m_card);
        end
      end
      if (host_hold && !s_axis_ready) begin
        axis_drop_seen <= 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin : main_seq
    int wait_cnt;
    build_stimulus();
    expect_route(req_list, beat_list, host_exp, card_exp);
    sq_exp = req_list;
    repeat (16) @(posedge aclk);
    aresetn <= 1'b1;
    @(posedge aclk);
    // Idle outputs before any traffic
    check_flag("m_sq_valid", 1'b0, m_sq_valid);
    check_flag("m_host_valid", 1'b0, m_host_valid);
    check_flag("m_card_valid", 1'b0, m_card_valid);
    check_flag("s_rq_ready", 1'b0, s_rq_ready);
    check_flag("s_axis_ready", 1'b1, s_axis_ready);
    fork
      drive_requests();
      drive_beats();
      stall_host();
    join_none
    wait_cnt = 0;
    while (sq_exp.size() != 0 || host_exp.size() != 0 || card_exp.size() != 0) begin
      @(posedge aclk);
      wait_cnt++;
      if (wait_cnt > DRAIN_LIMIT) begin
        abort_run("Timed out waiting for all requests and beats to leave the router");
      end
    end
    // Catch stray beats after the last expected one
    repeat (20) @(posedge aclk);
    if (axis_drop_seen) begin
      $display("TEST PASS");
      $finish;
    end else begin
      abort_run("s_axis_ready never dropped during the host stall");
    end
  end

endmodule

/* compile.f */
+incdir+include
verilog/rdma_req_pkg.sv
verilog/axis_beat_pkg.sv
verilog/sync_fifo.sv
verilog/dest_credit_port.sv
verilog/wr_route_ctrl.sv
verilog/wr_data_router_top.sv
testbench/tb_wr_data_router.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_wr_data_router
FILELIST  := compile.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(OBJ_DIR)

SRCS    := $(shell grep -v '^+' $(FILELIST))
HDRS    := $(wildcard include/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf $(OBJ_DIR)
